/* common/video_timing_pkg.sv */
package video_timing_pkg;

	// horizontal edges, in c3 positions within the line
	localparam logic [8:0] HBLNK_BEG = 9'd0;   // video ends, blank begins
	localparam logic [8:0] HSYNC_BEG = 9'd10;
	localparam logic [8:0] HSYNC_END = 9'd43;  // 33 strobes of sync
	localparam logic [8:0] HBLNK_END = 9'd88;

	// pixel window, pentagon x256 and atm x320
	localparam logic [8:0] HPIX_BEG_PENT = 9'd140;
	localparam logic [8:0] HPIX_END_PENT = 9'd396;
	localparam logic [8:0] HPIX_BEG_ATM  = 9'd108;
	localparam logic [8:0] HPIX_END_ATM  = 9'd428;

	localparam logic [8:0] FETCH_FOREGO = 9'd18; // go leads the pixels by this much
	localparam logic [8:0] SCANIN_BEG   = 9'd88; // scan-doubler begins storing
	localparam logic [8:0] HINT_BEG     = 9'd2;  // int position inside the line

	// vertical edges, in lines
	localparam logic [8:0] VSYNC_BEG = 9'd240;
	localparam logic [8:0] VSYNC_END = 9'd244;
	localparam logic [8:0] VBLNK_BEG = 9'd240;
	localparam logic [8:0] VBLNK_END = 9'd272;

	localparam logic [8:0] VPIX_BEG_PENT = 9'd64;  // 192 visible lines
	localparam logic [8:0] VPIX_END_PENT = 9'd256;
	localparam logic [8:0] VPIX_BEG_ATM  = 9'd56;  // 200 visible lines
	localparam logic [8:0] VPIX_END_ATM  = 9'd256;

	localparam logic [8:0] VINT_BEG = 9'd239; // line just before vsync

endpackage

/* common/video_mode_pkg.sv */
package video_mode_pkg;

	// screen mode, picks the horizontal and vertical windows
	typedef enum logic
	{
		MODE_PENT = 1'b0, // 256 pixels wide
		MODE_ATM  = 1'b1  // 320 pixels wide
	} video_mode_t;

	// dram cycle phases, c2 and c3 decoded from the last two
	typedef enum logic [1:0]
	{
		PH_C0 = 2'd0,
		PH_C1 = 2'd1,
		PH_C2 = 2'd2,
		PH_C3 = 2'd3
	} dram_phase_t;

	typedef enum logic
	{
		FETCH_IDLE = 1'b0,
		FETCH_GO   = 1'b1
	} fetch_state_t;

endpackage

/* verilog/dram_phase_gen.sv */
`timescale 1ns/10ps

// stands in for the cycle sequencer of the dram controller
// one phase per clk, so c2 and c3 each come once every four clk
module dram_phase_gen
(
	input  logic clk,
	input  logic rst_n,

	output logic c2, // one clk ahead of c3
	output logic c3  // 7 MHz video enable
);

	video_mode_pkg::dram_phase_t phase;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			phase <= video_mode_pkg::PH_C0;
			c2    <= 1'b0;
			c3    <= 1'b0;
		end
		else
		begin
			phase <= video_mode_pkg::dram_phase_t'(phase + 2'd1); // wraps c3 -> c0

			// decode one phase early so the strobe lines up with its own phase
			c2 <= (phase == video_mode_pkg::PH_C1); // high while in PH_C2
			c3 <= (phase == video_mode_pkg::PH_C2); // high while in PH_C3
		end
	end

endmodule

/* video_sync/video_sync_h.sv */
`timescale 1ns/10ps

// horizontal raster timing, counts c3 strobes through one line
//
// hcount 0: blank begins, 10: sync begins, 43: sync ends,
// 88: blank ends, line_start and scanin_start
// pixel window and fetch pulses depend on mode and text flag
module video_sync_h
#(
	parameter int LINE_PERIOD = 448
)
(
	input  logic                      clk,
	input  logic                      rst_n,

	input  logic                      c2,        // strobe one clk before c3
	input  logic                      c3,        // video clock enable
	input  logic                      line_init, // read on c3, rephases the line

	input  video_mode_pkg::video_mode_t mode,
	input  logic                      text_mode, // fetch starts 4 strobes earlier

	output logic                      hblank,
	output logic                      hsync,
	output logic                      hpix,      // pixels are going out

	// single clk pulses, registered on c2 so they coincide with c3
	output logic                      line_start,
	output logic                      hsync_start, // used by vertical timing
	output logic                      scanin_start,
	output logic                      hint_start,
	output logic                      fetch_start,
	output logic                      fetch_end
);

	localparam logic [8:0] TEXT_LEAD = 9'd4; // extra c3 lead in text mode

	logic [8:0] hcount;

	logic [8:0] hpix_beg;
	logic [8:0] hpix_end;
	logic [8:0] fstart_pos;
	logic [8:0] fend_pos;

	logic       fstart_time;
	logic       fstart_cond;
	logic [3:0] fstart_wait; // delays fstart_time by 4 c3 for graphics

	// window edges of the current mode
	always_comb
	begin
		if (mode == video_mode_pkg::MODE_ATM)
		begin
			hpix_beg = video_timing_pkg::HPIX_BEG_ATM;
			hpix_end = video_timing_pkg::HPIX_END_ATM;
		end
		else
		begin
			hpix_beg = video_timing_pkg::HPIX_BEG_PENT;
			hpix_end = video_timing_pkg::HPIX_END_PENT;
		end
	end

	// early start point, text mode uses it directly
	assign fstart_pos  = hpix_beg - video_timing_pkg::FETCH_FOREGO - TEXT_LEAD;
	assign fend_pos    = hpix_end - video_timing_pkg::FETCH_FOREGO;
	assign fstart_time = (hcount == fstart_pos);
	assign fstart_cond = text_mode ? fstart_time : fstart_wait[3];

	// line counter
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			hcount <= 9'd0;
		else if (c3)
		begin
			if (line_init || (hcount == 9'(LINE_PERIOD - 1)))
				hcount <= 9'd0;
			else
				hcount <= hcount + 9'd1;
		end
	end

	// levels, set and cleared on the c3 at the edge position
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hblank      <= 1'b0;
			hsync       <= 1'b0;
			hpix        <= 1'b0;
			fstart_wait <= 4'd0;
		end
		else if (c3)
		begin
			if (hcount == video_timing_pkg::HBLNK_BEG)
				hblank <= 1'b1;
			else if (hcount == video_timing_pkg::HBLNK_END)
				hblank <= 1'b0;

			if (hcount == video_timing_pkg::HSYNC_BEG)
				hsync <= 1'b1;
			else if (hcount == video_timing_pkg::HSYNC_END)
				hsync <= 1'b0;

			if (hcount == hpix_beg)
				hpix <= 1'b1;
			else if (hcount == hpix_end)
				hpix <= 1'b0;

			fstart_wait <= {fstart_wait[2:0], fstart_time}; // shifts once per c3
		end
	end

	// pulses, hcount is stable on c2 since it only moves on c3
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hsync_start  <= 1'b0;
			line_start   <= 1'b0;
			scanin_start <= 1'b0;
			hint_start   <= 1'b0;
			fetch_start  <= 1'b0;
			fetch_end    <= 1'b0;
		end
		else
		begin
			hsync_start  <= c2 && (hcount == video_timing_pkg::HSYNC_BEG);
			line_start   <= c2 && (hcount == video_timing_pkg::HBLNK_END);
			scanin_start <= c2 && (hcount == video_timing_pkg::SCANIN_BEG);
			hint_start   <= c2 && (hcount == video_timing_pkg::HINT_BEG);
			fetch_start  <= c2 && fstart_cond;
			fetch_end    <= c2 && (hcount == fend_pos); // same lead in every mode
		end
	end

endmodule

/* video_sync/video_sync_v.sv */
`timescale 1ns/10ps

// vertical raster timing, counts lines through one frame
// lines move on hsync_start, so all levels change just ahead of hsync
module video_sync_v
#(
	parameter int FRAME_LINES = 320
)
(
	input  logic                        clk,
	input  logic                        rst_n,

	input  logic                        hsync_start, // one pulse per line
	input  logic                        hint_start,  // int position inside the line

	input  video_mode_pkg::video_mode_t mode,

	output logic                        vblank,
	output logic                        vsync,
	output logic                        vpix,      // visible line
	output logic                        int_start  // once per frame
);

	logic [8:0] vcount;

	logic [8:0] vpix_beg;
	logic [8:0] vpix_end;

	always_comb
	begin
		if (mode == video_mode_pkg::MODE_ATM)
		begin
			vpix_beg = video_timing_pkg::VPIX_BEG_ATM;
			vpix_end = video_timing_pkg::VPIX_END_ATM;
		end
		else
		begin
			vpix_beg = video_timing_pkg::VPIX_BEG_PENT;
			vpix_end = video_timing_pkg::VPIX_END_PENT;
		end
	end

	// frame counter
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			vcount <= 9'd0;
		else if (hsync_start)
		begin
			if (vcount == 9'(FRAME_LINES - 1))
				vcount <= 9'd0;
			else
				vcount <= vcount + 9'd1;
		end
	end

	// vertical levels
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vsync  <= 1'b0;
			vblank <= 1'b0;
			vpix   <= 1'b0;
		end
		else if (hsync_start)
		begin
			if (vcount == video_timing_pkg::VSYNC_BEG)
				vsync <= 1'b1;
			else if (vcount == video_timing_pkg::VSYNC_END)
				vsync <= 1'b0; // 4 lines of sync

			if (vcount == video_timing_pkg::VBLNK_BEG)
				vblank <= 1'b1;
			else if (vcount == video_timing_pkg::VBLNK_END)
				vblank <= 1'b0;

			if (vcount == vpix_beg)
				vpix <= 1'b1;
			else if (vcount == vpix_end)
				vpix <= 1'b0;
		end
	end

	// int lands on one point of the frame: the int line at the int column
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			int_start <= 1'b0;
		else
			int_start <= hint_start && (vcount == video_timing_pkg::VINT_BEG);
	end

endmodule

/* verilog/video_fetch_gate.sv */
`timescale 1ns/10ps

// makes the fetcher's go level out of the fetch pulse pair
// invisible lines never start fetching
module video_fetch_gate
(
	input  logic clk,
	input  logic rst_n,

	input  logic fetch_start, // from horizontal timing, coincides with c3
	input  logic fetch_end,
	input  logic vpix,        // current line is visible

	output logic fetch_go
);

	video_mode_pkg::fetch_state_t state;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= video_mode_pkg::FETCH_IDLE;
		else if (fetch_start)
		begin
			// start pulse on a blank line drops back to idle
			if (vpix)
				state <= video_mode_pkg::FETCH_GO;
			else
				state <= video_mode_pkg::FETCH_IDLE;
		end
		else if (fetch_end)
			state <= video_mode_pkg::FETCH_IDLE;
	end

	assign fetch_go = (state == video_mode_pkg::FETCH_GO); // one clk after the pulse

endmodule

/* verilog/video_sync_top.sv */
`timescale 1ns/10ps

// raster timing generator
// phase strobes -> line timing -> frame timing -> fetch gate
module video_sync_top
#(
	parameter int LINE_PERIOD = 448, // c3 strobes per line
	parameter int FRAME_LINES = 320  // lines per frame
)
(
	input  logic                        clk,
	input  logic                        rst_n,

	input  logic                        line_init, // rephase the line from cpu side
	input  video_mode_pkg::video_mode_t mode,
	input  logic                        text_mode,

	output logic                        c2,
	output logic                        c3,

	output logic                        hsync,
	output logic                        hblank,
	output logic                        hpix,
	output logic                        line_start,
	output logic                        scanin_start,

	output logic                        vsync,
	output logic                        vblank,
	output logic                        vpix,
	output logic                        int_start,

	output logic                        fetch_go
);

	logic hsync_start; // line step for vertical timing
	logic hint_start;
	logic fetch_start;
	logic fetch_end;

	dram_phase_gen u_phase
	(
		.clk   (clk),
		.rst_n (rst_n),
		.c2    (c2),
		.c3    (c3)
	);

	video_sync_h #(.LINE_PERIOD(LINE_PERIOD)) u_sync_h
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.c2           (c2),
		.c3           (c3),
		.line_init    (line_init),
		.mode         (mode),
		.text_mode    (text_mode),
		.hblank       (hblank),
		.hsync        (hsync),
		.hpix         (hpix),
		.line_start   (line_start),
		.hsync_start  (hsync_start),
		.scanin_start (scanin_start),
		.hint_start   (hint_start),
		.fetch_start  (fetch_start),
		.fetch_end    (fetch_end)
	);

	video_sync_v #(.FRAME_LINES(FRAME_LINES)) u_sync_v
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.hsync_start (hsync_start),
		.hint_start  (hint_start),
		.mode        (mode),
		.vblank      (vblank),
		.vsync       (vsync),
		.vpix        (vpix),
		.int_start   (int_start)
	);

	video_fetch_gate u_fetch_gate
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_start (fetch_start),
		.fetch_end   (fetch_end),
		.vpix        (vpix),
		.fetch_go    (fetch_go)
	);

endmodule

/* testbench/tb_video_sync.sv */
`timescale 1ns/10ps

module tb_video_sync;

	localparam int LINE_PERIOD  = 448; // c3 strobes per line
	localparam int FRAME_LINES  = 320;
	localparam int INT_TO_VSYNC = LINE_PERIOD + 10 - 2; // int at column 2, vsync at column 10 a line on
	localparam int INIT_TO_HS   = 1 + 10; // the init strobe itself, then hcount 0 up to sync at 10
	localparam int MAX_CYCLES   = 4 * FRAME_LINES * LINE_PERIOD * 4 + 200_000; // four frames

	logic clk   = 1'b0;
	logic rst_n = 1'b0;
	logic line_init;
	logic text_mode;
	video_mode_pkg::video_mode_t mode;
	logic c2, c3, hsync, hblank, hpix, line_start, scanin_start;
	logic vsync, vblank, vpix, int_start, fetch_go;

	// everything except the phase strobes
	wire [9:0] quiet = {hsync, hblank, hpix, line_start, scanin_start, vsync, vblank, vpix,
		int_start, fetch_go};

	int cycles = 0;
	int err_count = 0;
	int errs_at_start = 0;
	int tests_failed = 0;
	int clk_cnt = 0;   // clk since reset release
	int c3_cnt = 0;    // c3 strobes since reset release
	int lines = 0;     // hsync rises
	int c2_clk, hs_c3, hb_c3, hp_c3, hp_len, go_rise_c3, go_fall_c3, init_c3, int_c3;
	int vs_line, vp_line, vp_len;
	int ls_count = 0;
	int sc_count = 0;
	int int_count = 0;
	bit c2_seen, c3_seen, hs_seen, vs_seen, init_pending;
	logic c2_q, hsync_q, hblank_q, hpix_q, vsync_q, vpix_q, int_q, go_q;

	video_sync_top DUT (.*);

	initial
	begin
		forever #20 clk = ~clk;
	end

	task automatic check(input bit ok, input string msg);
		assert (ok)
		else
		begin
			err_count++;
			$display("error at %0d ns: %s", $time, msg);
		end
	endtask

	// runs to the end of the visible field, then sets the next mode inside vblank
	task automatic run_frame(input int num, input string name,
		input video_mode_pkg::video_mode_t next_mode, input bit next_text);
		@(negedge vpix);
		@(posedge clk); // lets the monitor see the vpix fall
		if (err_count == errs_at_start)
			$display("test %0d %s: passed", num, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", num, name,
				err_count - errs_at_start);
		end
		errs_at_start = err_count;
		#2;
		check(vblank, "mode change fell outside vblank");
		mode      = next_mode;
		text_mode = next_text;
	endtask

	// one line_init pulse at a random column past the widest pixel window
	task automatic rephase_line();
		int pos;
		int n;
		pos = 430 + int'($urandom % 16);
		n   = 0;
		wait (vpix); // mid frame, well away from the int line
		repeat (4) @(posedge hsync);
		while (n < pos - 10)
		begin
			@(posedge clk);
			#2;
			if (c3)
				n++; // c3 strobe at column 10 + n
		end
		line_init = 1'b1;
		@(posedge clk);
		#2 line_init = 1'b0;
	endtask

	initial
	begin
		line_init = 1'b0;
		text_mode = 1'b0;
		mode      = video_mode_pkg::MODE_PENT;
		void'($urandom(32'hef5258e1));
		repeat (4) @(posedge clk);
		#2 rst_n = 1'b1;
		run_frame(1, "pentagon graphics", video_mode_pkg::MODE_PENT, 1'b1);
		run_frame(2, "pentagon text", video_mode_pkg::MODE_ATM, 1'b0);
		run_frame(3, "atm graphics", video_mode_pkg::MODE_ATM, 1'b0);
		rephase_line();
		run_frame(4, "line_init rephase", video_mode_pkg::MODE_ATM, 1'b0);
		$display("tests 4, failed %0d, errors %0d", tests_failed, err_count);
		if (err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d clk", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// monitor, samples at the falling edge where every output is settled
	always @(negedge clk)
	begin
		if (!rst_n)
			check({c2, c3, quiet} == '0, "outputs not 0 during reset");
		else
		begin
			clk_cnt++;
			check(!(c2 && c3), "c2 and c3 high together");
			check(c3 == c2_q, "c3 not one clk after c2");
			if (c2)
			begin
				check(!c2_seen || clk_cnt - c2_clk == 4, "c2 not once every four clk");
				c2_seen = 1;
				c2_clk  = clk_cnt;
			end
			if (!c3_seen)
				check(quiet == '0, "outputs moved before the first c3");
			if (c3)
			begin
				c3_cnt++;
				c3_seen = 1;
			end
			if (c3 && line_init)
			begin
				init_c3      = c3_cnt;
				init_pending = 1;
			end

			if (hsync && !hsync_q)
			begin
				lines++;
				if (init_pending)
					check(c3_cnt - init_c3 == INIT_TO_HS,
						"hsync not 10 strobes after line restart");
				else if (hs_seen)
					check(c3_cnt - hs_c3 == LINE_PERIOD, "hsync rises not 448 strobes apart");
				check(!hs_seen || ls_count == 1, "line_start not once per line");
				check(!hs_seen || sc_count == 1, "scanin_start not once per line");
				init_pending = 0;
				hs_seen      = 1;
				hs_c3        = c3_cnt;
				ls_count     = 0;
				sc_count     = 0;
			end
			if (!hsync && hsync_q)
				check(c3_cnt - hs_c3 == 33, "hsync not 33 strobes wide");
			if (hblank && !hblank_q)
				hb_c3 = c3_cnt;
			if (!hblank && hblank_q)
				check(c3_cnt - hb_c3 == 88, "hblank not 88 strobes wide");
			if (line_start)
			begin
				ls_count++;
				check(c3 && c3_cnt - hs_c3 == 78, "line_start not 78 strobes after hsync rise");
			end
			if (scanin_start)
			begin
				sc_count++; // scan-doubler start at column 88
				check(c3 && c3_cnt - hs_c3 == 78,
					"scanin_start not 78 strobes after hsync rise");
			end

			if (fetch_go && !go_q)
				go_rise_c3 = c3_cnt;
			if (!fetch_go && go_q)
				go_fall_c3 = c3_cnt;
			check(!(fetch_go && !vpix), "fetch_go high on an invisible line");
			if (hpix && !hpix_q)
			begin
				hp_c3  = c3_cnt;
				hp_len = (mode == video_mode_pkg::MODE_ATM) ? 320 : 256;
				if (vpix)
					check(fetch_go && c3_cnt - go_rise_c3 == (text_mode ? 22 : 18),
						"fetch_go lead before hpix rise wrong");
			end
			if (!hpix && hpix_q)
			begin
				check(c3_cnt - hp_c3 == hp_len, "hpix width wrong for the mode");
				if (vpix)
					check(!fetch_go && c3_cnt - go_fall_c3 == 18,
						"fetch_go not 18 strobes before hpix fall");
			end

			if (vsync && !vsync_q)
			begin
				check(!vs_seen || lines - vs_line == FRAME_LINES,
					"vsync rises not 320 lines apart");
				check(int_count == 1 && c3_cnt - int_c3 == INT_TO_VSYNC,
					"int_start not once per frame on the line before vsync");
				vs_seen   = 1;
				vs_line   = lines;
				int_count = 0;
			end
			if (!vsync && vsync_q)
				check(lines - vs_line == 4, "vsync not 4 lines long");
			if (vpix && !vpix_q)
			begin
				vp_line = lines;
				vp_len  = (mode == video_mode_pkg::MODE_ATM) ? 200 : 192;
			end
			if (!vpix && vpix_q)
				check(lines - vp_line == vp_len, "vpix height wrong for the mode");
			if (int_start)
			begin
				int_count++;
				int_c3 = c3_cnt;
				check(!int_q, "int_start longer than one clk");
			end
		end
		c2_q     = c2;
		hsync_q  = hsync;
		hblank_q = hblank;
		hpix_q   = hpix;
		vsync_q  = vsync;
		vpix_q   = vpix;
		int_q    = int_start;
		go_q     = fetch_go;
	end

endmodule

/* src.f */
common/video_timing_pkg.sv
common/video_mode_pkg.sv
verilog/dram_phase_gen.sv
video_sync/video_sync_h.sv
video_sync/video_sync_v.sv
verilog/video_fetch_gate.sv
verilog/video_sync_top.sv
testbench/tb_video_sync.sv

/* Makefile */
# Verilator build for the raster timing generator

VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= tb_video_sync
LINT_TOP  ?= video_sync_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/10ps

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
